// File: rtl/rf_pkg.sv
// ----------------------------------------
// Shared definitions of the execute pipeline
// Widths and the register file port map
// Data and address types, ALU op encoding
// Instruction, load, result, execute structs
// ----------------------------------------
`default_nettype none

package rf_pkg;

  // Datapath and register file geometry
  localparam int unsigned DATA_WIDTH  = 32;
  localparam int unsigned ADDR_WIDTH  = 5;
  localparam int unsigned NUM_REGS    = 2**ADDR_WIDTH;
  // Shifts only look at the low bits of the second operand
  localparam int unsigned SHAMT_WIDTH = 5;

  // Register file ports as used by the core
  localparam int unsigned NR_READ_PORTS  = 3;
  localparam int unsigned NR_WRITE_PORTS = 2;

  // Read port assignment
  localparam int unsigned RD_PORT_A   = 0;
  localparam int unsigned RD_PORT_B   = 1;
  localparam int unsigned RD_PORT_DBG = 2;

  // Write port assignment, the load port wins a conflict
  localparam int unsigned WR_PORT_WB   = 0;
  localparam int unsigned WR_PORT_LOAD = 1;

  typedef logic [DATA_WIDTH-1:0] rf_data_t;
  typedef logic [ADDR_WIDTH-1:0] rf_addr_t;

  // ALU operations, all eight codes are taken
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_SLL  = 3'd5,
    ALU_SRL  = 3'd6,
    ALU_ADDI = 3'd7
  } alu_op_e;

  // Incoming instruction, imm only matters for ALU_ADDI
  typedef struct packed {
    logic     valid;
    alu_op_e  op;
    rf_addr_t rd;
    rf_addr_t rs1;
    rf_addr_t rs2;
    rf_data_t imm;
  } instr_t;

  // External register preload
  typedef struct packed {
    logic     valid;
    rf_addr_t addr;
    rf_data_t data;
  } load_t;

  // Result of one instruction
  // Also used as writeback register and forwarding source
  typedef struct packed {
    logic     valid;
    rf_addr_t rd;
    rf_data_t data;
  } result_t;

  // Execute stage register with resolved operands
  typedef struct packed {
    logic     valid;
    alu_op_e  op;
    rf_addr_t rd;
    rf_data_t op_a;
    rf_data_t op_b;
  } ex_t;

endpackage

`default_nettype wire

// File: rtl/rf_regfile.sv
// ----------------------------------------
// Flip-flop register file
// Parameterized read and write port counts
// Write decoder per port, last port wins
// Optional x0 tied to zero
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rf_regfile #(
  parameter int unsigned NR_READ_PORTS  = 2,
  parameter int unsigned NR_WRITE_PORTS = 1,
  parameter bit          ZERO_REG_ZERO  = 1'b0
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Combinational read ports
  input  rf_pkg::rf_addr_t [NR_READ_PORTS-1:0]       raddr_i,
  output rf_pkg::rf_data_t [NR_READ_PORTS-1:0]       rdata_o,
  // Synchronous write ports
  input  rf_pkg::rf_addr_t [NR_WRITE_PORTS-1:0]      waddr_i,
  input  rf_pkg::rf_data_t [NR_WRITE_PORTS-1:0]      wdata_i,
  input  logic             [NR_WRITE_PORTS-1:0]      we_i
);
  import rf_pkg::*;

  // Register array
  rf_data_t [NUM_REGS-1:0]                    mem;
  // One-hot write enables, one row per write port
  logic     [NR_WRITE_PORTS-1:0][NUM_REGS-1:0] we_dec;

  // Address decode of every write port
  always_comb begin
    for (int unsigned j = 0; j < NR_WRITE_PORTS; j++) begin
      for (int unsigned i = 0; i < NUM_REGS; i++) begin
        we_dec[j][i] = we_i[j] && (waddr_i[j] == rf_addr_t'(i));
      end
    end
  end

  // Ports are applied in ascending order
  // so the higher-numbered port overwrites a lower one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem <= '0;
    end else begin
      for (int unsigned j = 0; j < NR_WRITE_PORTS; j++) begin
        for (int unsigned i = 0; i < NUM_REGS; i++) begin
          if (we_dec[j][i]) begin
            mem[i] <= wdata_i[j];
          end
        end
      end
      // x0 stays zero whatever was written to it
      if (ZERO_REG_ZERO) begin
        mem[0] <= '0;
      end
    end
  end

  // Reads see the committed state only, no write bypass
  for (genvar r = 0; r < NR_READ_PORTS; r++) begin : g_read
    assign rdata_o[r] = mem[raddr_i[r]];
  end

  // Two enabled ports never aim at the same register
  for (genvar a = 0; a < NR_WRITE_PORTS; a++) begin : g_wr_a
    for (genvar b = a + 1; b < NR_WRITE_PORTS; b++) begin : g_wr_b
      a_no_write_conflict : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(we_i[a] && we_i[b] && (waddr_i[a] == waddr_i[b]))
      ) else $error("Write ports %0d and %0d hit the same register", a, b);
    end
  end

endmodule

`default_nettype wire

// File: rtl/rf_operand_fetch.sv
// ----------------------------------------
// Operand fetch stage
// Register reads for rs1 and rs2
// Forwarding from execute and writeback
// Immediate select, execute stage register
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rf_operand_fetch (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Instruction strobe, one per cycle at most
  input  rf_pkg::instr_t         instr_i,
  // Register file read ports 0 and 1
  output rf_pkg::rf_addr_t [1:0] raddr_o,
  input  rf_pkg::rf_data_t [1:0] rdata_i,
  // Forwarding from the two later stages
  input  rf_pkg::result_t        ex_res_i,
  input  rf_pkg::result_t        wb_i,
  // Execute stage register
  output rf_pkg::ex_t            ex_o
);
  import rf_pkg::*;

  ex_t      ex_d;
  ex_t      ex_data_q;
  logic     ex_valid_q;
  rf_data_t rs1_val;
  rf_data_t rs2_val;

  // Picks the newest value of a source register
  // Execute result is one instruction old, wb two, regfile older
  function automatic rf_data_t fwd_select(
    input rf_addr_t rs,
    input rf_data_t rf_val,
    input result_t  ex_res,
    input result_t  wb
  );
    rf_data_t val;
    if (rs == '0) begin
      // x0 is never forwarded, even when an older op wrote it
      val = '0;
    end else if (ex_res.valid && (ex_res.rd == rs)) begin
      val = ex_res.data;
    end else if (wb.valid && (wb.rd == rs)) begin
      val = wb.data;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  // Source addresses go straight to the register file
  assign raddr_o[0] = instr_i.rs1;
  assign raddr_o[1] = instr_i.rs2;

  assign rs1_val = fwd_select(instr_i.rs1, rdata_i[0], ex_res_i, wb_i);
  assign rs2_val = fwd_select(instr_i.rs2, rdata_i[1], ex_res_i, wb_i);

  // Next execute stage contents
  always_comb begin
    ex_d.valid = instr_i.valid;
    ex_d.op    = instr_i.op;
    ex_d.rd    = instr_i.rd;
    ex_d.op_a  = rs1_val;
    // ADDI takes the immediate in place of rs2
    if (instr_i.op == ALU_ADDI) begin
      ex_d.op_b = instr_i.imm;
    end else begin
      ex_d.op_b = rs2_val;
    end
  end

  // Stage valid, dropped whenever no instruction arrives
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_valid_q <= 1'b0;
    end else begin
      ex_valid_q <= instr_i.valid;
    end
  end

  // Payload only moves with a valid instruction
  always_ff @(posedge clk_i) begin
    if (instr_i.valid) begin
      ex_data_q <= ex_d;
    end
  end

  // Payload with the reset-cleared valid on top
  always_comb begin
    ex_o       = ex_data_q;
    ex_o.valid = ex_valid_q;
  end

endmodule

`default_nettype wire

// File: rtl/rf_alu_writeback.sv
// ----------------------------------------
// ALU and writeback stage
// Combinational execute result
// Writeback register, result strobe source
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rf_alu_writeback (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Execute stage register from fetch
  input  rf_pkg::ex_t     ex_i,
  // Execute result, forwarded to fetch in the same cycle
  output rf_pkg::result_t ex_res_o,
  // Writeback register, feeds regfile port 0 and the result output
  output rf_pkg::result_t wb_o
);
  import rf_pkg::*;

  rf_data_t alu_res;
  logic     wb_valid_q;
  result_t  wb_data_q;

  // ALU, all arithmetic wraps at 32 bits
  always_comb begin
    case (ex_i.op)
      ALU_ADD,
      ALU_ADDI: alu_res = ex_i.op_a + ex_i.op_b;
      ALU_SUB:  alu_res = ex_i.op_a - ex_i.op_b;
      ALU_AND:  alu_res = ex_i.op_a & ex_i.op_b;
      ALU_OR:   alu_res = ex_i.op_a | ex_i.op_b;
      ALU_XOR:  alu_res = ex_i.op_a ^ ex_i.op_b;
      // Shift amount from the low 5 bits only
      ALU_SLL:  alu_res = ex_i.op_a << ex_i.op_b[SHAMT_WIDTH-1:0];
      // Logical shift, zeros come in from the top
      ALU_SRL:  alu_res = ex_i.op_a >> ex_i.op_b[SHAMT_WIDTH-1:0];
      default:  alu_res = '0;
    endcase
  end

  // Result of the instruction currently in execute
  always_comb begin
    ex_res_o.valid = ex_i.valid;
    ex_res_o.rd    = ex_i.rd;
    ex_res_o.data  = alu_res;
  end

  // Writeback valid, one strobe per executed instruction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= ex_i.valid;
    end
  end

  // Destination and data, held while the stage is empty
  always_ff @(posedge clk_i) begin
    if (ex_i.valid) begin
      wb_data_q <= ex_res_o;
    end
  end

  always_comb begin
    wb_o       = wb_data_q;
    wb_o.valid = wb_valid_q;
  end

  // All eight codes are used, so only an unknown op is out of range
  // catches X from an uninitialised execute payload
  a_op_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ex_i.valid |-> !$isunknown(ex_i.op)
  ) else $error("Undefined ALU op %0d in execute", ex_i.op);

endmodule

`default_nettype wire

// File: rtl/rf_core.sv
// ----------------------------------------
// Execute pipeline top level
// Fetch, register file, ALU and writeback
// Load port and debug read-out
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rf_core (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Instruction and preload strobes
  input  rf_pkg::instr_t   instr_i,
  input  rf_pkg::load_t    load_i,
  // One result per instruction, two edges after issue
  output rf_pkg::result_t  res_o,
  // Combinational read of the committed registers
  input  rf_pkg::rf_addr_t dbg_addr_i,
  output rf_pkg::rf_data_t dbg_data_o
);
  import rf_pkg::*;

  ex_t      ex_q;
  result_t  ex_res;
  result_t  wb_q;

  // Register file port bundles
  rf_addr_t [NR_READ_PORTS-1:0]  rf_raddr;
  rf_data_t [NR_READ_PORTS-1:0]  rf_rdata;
  rf_addr_t [NR_WRITE_PORTS-1:0] rf_waddr;
  rf_data_t [NR_WRITE_PORTS-1:0] rf_wdata;
  logic     [NR_WRITE_PORTS-1:0] rf_we;

  // Operand fetch drives read ports 0 and 1
  rf_operand_fetch i_fetch (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .instr_i  (instr_i),
    .raddr_o  (rf_raddr[RD_PORT_B:RD_PORT_A]),
    .rdata_i  (rf_rdata[RD_PORT_B:RD_PORT_A]),
    .ex_res_i (ex_res),
    .wb_i     (wb_q),
    .ex_o     (ex_q)
  );

  // Debug read-out on port 2
  assign rf_raddr[RD_PORT_DBG] = dbg_addr_i;
  assign dbg_data_o            = rf_rdata[RD_PORT_DBG];

  // Writeback commits through port 0, preloads through port 1
  assign rf_we[WR_PORT_WB]      = wb_q.valid;
  assign rf_waddr[WR_PORT_WB]   = wb_q.rd;
  assign rf_wdata[WR_PORT_WB]   = wb_q.data;
  assign rf_we[WR_PORT_LOAD]    = load_i.valid;
  assign rf_waddr[WR_PORT_LOAD] = load_i.addr;
  assign rf_wdata[WR_PORT_LOAD] = load_i.data;

  rf_regfile #(
    .NR_READ_PORTS  (NR_READ_PORTS),
    .NR_WRITE_PORTS (NR_WRITE_PORTS),
    .ZERO_REG_ZERO  (1'b1)
  ) i_regfile (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .raddr_i (rf_raddr),
    .rdata_o (rf_rdata),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .we_i    (rf_we)
  );

  rf_alu_writeback i_alu_wb (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .ex_i     (ex_q),
    .ex_res_o (ex_res),
    .wb_o     (wb_q)
  );

  assign res_o = wb_q;

  // Loads only into an empty pipeline, and never to x0
  a_load_when_idle : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    load_i.valid |-> (!instr_i.valid && !ex_q.valid && !wb_q.valid &&
                      (load_i.addr != '0))
  ) else $error("Load to x%0d while the pipeline is busy", load_i.addr);

endmodule

`default_nettype wire

// File: sim/tb_rf_model.svh
// ----------------------------------------
// Reference model of the execute pipeline
// Architectural registers in program order
// Queue of expected results with due cycle
// Typed compare tasks
// ----------------------------------------
`ifndef TB_RF_MODEL_SVH
`define TB_RF_MODEL_SVH

  // Registers as a sequential machine sees them, x0 never written
  rf_data_t    model_regs [NUM_REGS] = '{default: '0};
  // Results still owed by the DUT, oldest first
  result_t     exp_q [$];
  // Cycle count at which each result must be on res_o
  int unsigned due_q [$];

  // ALU rules, everything wraps at 32 bits
  function automatic rf_data_t alu_model(input alu_op_e op, input rf_data_t a,
                                         input rf_data_t b);
    rf_data_t r;
    case (op)
      ALU_ADD, ALU_ADDI: r = a + b;
      // Two's complement subtract
      ALU_SUB: r = a + ~b + 1;
      ALU_AND: r = a & b;
      ALU_OR:  r = a | b;
      ALU_XOR: r = a ^ b;
      ALU_SLL: r = a << b[4:0];
      ALU_SRL: r = a >> b[4:0];
      default: r = '0;
    endcase
    return r;
  endfunction

  // Executes one instruction on the model and books its result
  task automatic model_issue(input instr_t in);
    rf_data_t a;
    rf_data_t b;
    result_t  exp_res;
    a = model_regs[in.rs1];
    b = (in.op == ALU_ADDI) ? in.imm : model_regs[in.rs2];
    exp_res.valid = 1'b1;
    exp_res.rd    = in.rd;
    exp_res.data  = alu_model(in.op, a, b);
    exp_q.push_back(exp_res);
    // Sampled at the next edge, on res_o one edge after that
    due_q.push_back(cycle + 2);
    if (in.rd != '0) begin
      model_regs[in.rd] = exp_res.data;
    end
  endtask

  task automatic check_result(input string name, input result_t exp_res, input result_t act);
    if (act !== exp_res) begin
      report_failure($sformatf("Error: %s expected rd=x%0d data=%h, actual rd=x%0d data=%h",
                               name, exp_res.rd, exp_res.data, act.rd, act.data));
    end
  endtask

  task automatic check_data(input string name, input rf_data_t exp_val, input rf_data_t act);
    if (act !== exp_val) begin
      report_failure($sformatf("Error: %s expected %h, actual %h", name, exp_val, act));
    end
  endtask

`endif

// File: sim/tb_rf_core.sv
// ----------------------------------------
// Testbench of the execute pipeline
// Clock, reset, seeded random stimulus
// Result monitor with latency check
// Load, ALU, forwarding and x0 sequences
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_rf_core;
  import rf_pkg::*;

  localparam int unsigned HALF_PERIOD   = 10;
  localparam int unsigned SEED          = 38;
  localparam int unsigned DRAIN_TIMEOUT = 20;

  logic        clk_i;
  logic        rst_ni;
  instr_t      instr_i;
  load_t       load_i;
  result_t     res_o;
  rf_addr_t    dbg_addr_i;
  rf_data_t    dbg_data_o;

  // Rising edges seen so far
  int unsigned cycle = 0;
  string       test_name;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "Stopped at the first failure");
  endtask

  `include "tb_rf_model.svh"

  rf_core dut0 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .instr_i    (instr_i),
    .load_i     (load_i),
    .res_o      (res_o),
    .dbg_addr_i (dbg_addr_i),
    .dbg_data_o (dbg_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #HALF_PERIOD clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  // Every strobe must be the oldest owed result, exactly on its due cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (res_o.valid) begin
        if (exp_q.size() == 0) begin
          report_failure("Result strobe arrived with no instruction in flight");
        end else begin
          if (due_q[0] != cycle) begin
            report_failure($sformatf("Result for x%0d came at cycle %0d but was due at %0d",
                                     res_o.rd, cycle, due_q[0]));
          end
          check_result(test_name, exp_q.pop_front(), res_o);
          void'(due_q.pop_front());
        end
      end else if ((exp_q.size() != 0) && (due_q[0] <= cycle)) begin
        report_failure("An expected result strobe never arrived");
      end
    end
  end

  function automatic instr_t random_instr();
    instr_t in;
    in.valid = 1'b1;
    in.op    = alu_op_e'(3'($urandom_range(7, 0)));
    in.rd    = rf_addr_t'($urandom_range(31, 0));
    in.rs1   = rf_addr_t'($urandom_range(31, 0));
    in.rs2   = rf_addr_t'($urandom_range(31, 0));
    in.imm   = rf_data_t'($urandom());
    return in;
  endfunction

  // Drives one instruction for a single cycle
  task automatic send_instr(input instr_t in);
    instr_i = in;
    model_issue(in);
    @(negedge clk_i);
    instr_i.valid = 1'b0;
  endtask

  task automatic load_register(input rf_addr_t addr, input rf_data_t data);
    load_i.valid = 1'b1;
    load_i.addr  = addr;
    load_i.data  = data;
    dbg_addr_i   = addr;
    model_regs[addr] = data;
    @(negedge clk_i);
    load_i.valid = 1'b0;
    check_data(test_name, model_regs[addr], dbg_data_o);
  endtask

  // Debug port is combinational, sampled mid low phase
  task automatic check_debug_read(input rf_addr_t addr);
    dbg_addr_i = addr;
    #(HALF_PERIOD / 2);
    check_data(test_name, model_regs[addr], dbg_data_o);
    @(negedge clk_i);
  endtask

  task automatic read_back_all();
    for (int unsigned a = 0; a < NUM_REGS; a++) begin
      check_debug_read(rf_addr_t'(a));
    end
  endtask

  task automatic drain_pipeline();
    int unsigned waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == DRAIN_TIMEOUT) begin
        report_failure("Pipeline did not drain within the timeout");
      end
      @(negedge clk_i);
      waited++;
    end
    // Last result commits at the following edge
    @(negedge clk_i);
  endtask

  initial begin
    instr_t   in;
    rf_addr_t prev_rd;
    rf_addr_t last_rd;
    void'($urandom(SEED));
    rst_ni     = 1'b0;
    instr_i    = '0;
    load_i     = '0;
    dbg_addr_i = '0;
    test_name  = "reset";
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    read_back_all();

    test_name = "load";
    for (int unsigned a = 1; a < NUM_REGS; a++) begin
      load_register(rf_addr_t'(a), rf_data_t'($urandom()));
    end
    read_back_all();

    // Random program, sometimes with idle gaps
    test_name = "random";
    repeat (300) begin
      send_instr(random_instr());
      if ($urandom_range(3, 0) == 0) begin
        repeat ($urandom_range(3, 1)) @(negedge clk_i);
      end
    end
    drain_pipeline();

    // Each op reads the last two destinations back to back
    test_name = "forwarding";
    prev_rd   = rf_addr_t'(1);
    last_rd   = rf_addr_t'(2);
    repeat (60) begin
      in     = random_instr();
      in.rd  = rf_addr_t'($urandom_range(31, 1));
      in.rs1 = last_rd;
      in.rs2 = prev_rd;
      send_instr(in);
      prev_rd = last_rd;
      last_rd = in.rd;
    end
    drain_pipeline();

    // Write x0, then read it straight away as an operand
    test_name = "x0";
    repeat (20) begin
      in    = random_instr();
      in.rd = '0;
      send_instr(in);
      in     = random_instr();
      in.rs1 = '0;
      send_instr(in);
    end
    drain_pipeline();
    check_debug_read('0);

    test_name = "final";
    read_back_all();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+sim
rtl/rf_pkg.sv
rtl/rf_regfile.sv
rtl/rf_operand_fetch.sv
rtl/rf_alu_writeback.sv
rtl/rf_core.sv
sim/tb_rf_core.sv

// File: Makefile
# Verilator build and run of the execute pipeline testbench
SIM  := obj_dir/Vtb_rf_core
SRCS := $(wildcard rtl/*.sv sim/*.sv sim/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): project.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_rf_core -f project.f -o Vtb_rf_core

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
